//--- sim.f
+incdir+common
common/matmul_pkg.sv
common/operand_if.sv
source/operand_bram.sv
matmul_core/mac_pe.sv
matmul_core/mac_array.sv
matmul_core/tile_sequencer.sv
source/matmul_w_bram.sv
bench/matmul_w_bram_tb.sv

//--- bench/matmul_w_bram_tb.sv
// Testbench for the matrix multiplier with operand RAMs
// Directed runs checked against a reference model of C = A*B in Q8.8
`timescale 1ns/1ps
`include "matmul_macros.svh"

module matmul_w_bram_tb;

    localparam int W           = `MM_WIDTH;
    localparam int NUM_TILES   = (`MM_ROWS_A / `MM_BLOCK) * (`MM_COLS_B / `MM_BLOCK);
    localparam int RUN_CYCLES  = NUM_TILES * `MM_INNER + 20;
    localparam int LOAD_CYCLES = 2 * (`MM_ROWS_A / `MM_BLOCK) * `MM_INNER;
    localparam int WAIT_LIMIT  = RUN_CYCLES * 4;   // Per run with back-pressure
    localparam int WATCHDOG_NS = (7 * RUN_CYCLES + 5 * LOAD_CYCLES + 16) * 4 * 8;
    localparam int HOLD_CYCLES = 3 * `MM_INNER;    // Past the second tile's last beat

    logic                                   clk;
    logic                                   rst_n;
    logic                                   start;
    logic                                   load_en;
    logic                                   load_sel;
    logic [`MM_ADDR_WIDTH-1:0]              load_addr;
    logic [`MM_BLOCK*W-1:0]                 load_data;
    logic                                   out_valid;
    logic                                   out_ready;
    logic [`MM_BLOCK*`MM_BLOCK*W-1:0]       out_data;
    logic                                   done;

    logic signed [W-1:0] a_m [`MM_ROWS_A][`MM_INNER];   // Model copy of A
    logic signed [W-1:0] b_m [`MM_INNER][`MM_COLS_B];   // Model copy of B
    logic [`MM_BLOCK*`MM_BLOCK*W-1:0] res_q [NUM_TILES]; // Results of last run
    logic [`MM_BLOCK*`MM_BLOCK*W-1:0] prev_q [NUM_TILES];
    int err_cnt;
    int pass_cnt;
    int fail_cnt;
    int seed_val;

    matmul_w_bram uut (.*);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;   // 8 ns period
    end

    // Reference element of C from the exact sum, shifted and clamped
    function automatic logic signed [W-1:0] model_elem(input int i, input int j);
        longint s;
        s = 0;
        for (int k = 0; k < `MM_INNER; k++) begin
            s += longint'(a_m[i][k]) * longint'(b_m[k][j]);
        end
        s = s >>> `MM_FRAC;                  // Floor like an arithmetic shift
        if (s > 32767) return 16'sh7FFF;
        if (s < -32768) return 16'sh8000;
        return W'(s);
    endfunction

    task automatic write_word(input logic sel, input int addr, input logic [2*W-1:0] data);
        @(posedge clk);
        #1;
        load_en   = 1'b1;
        load_sel  = sel;
        load_addr = addr[`MM_ADDR_WIDTH-1:0];
        load_data = data;
    endtask

    // Pack both matrices by the RAM layout rule
    task automatic load_matrices();
        for (int t = 0; t < 2; t++) begin
            for (int k = 0; k < `MM_INNER; k++) begin
                write_word(1'b0, t * `MM_INNER + k, {a_m[2*t+1][k], a_m[2*t][k]});
                write_word(1'b1, t * `MM_INNER + k, {b_m[k][2*t+1], b_m[k][2*t]});
            end
        end
        @(posedge clk);
        #1;
        load_en = 1'b0;
    endtask

    task automatic check_tile(input int idx, input logic [4*W-1:0] data);
        int tr;
        int tc;
        logic signed [W-1:0] exp_v;
        logic signed [W-1:0] act_v;
        tr = idx / 2;
        tc = idx % 2;
        for (int r = 0; r < 2; r++) begin
            for (int c = 0; c < 2; c++) begin
                exp_v = model_elem(2 * tr + r, 2 * tc + c);
                act_v = data[W*(2*r+c) +: W];    // Element (r,c) in the raw word
                if (act_v !== exp_v) begin
                    $display("MISMATCH at %0t ns: tile (%0d,%0d) elem (%0d,%0d) expected %h got %h",
                             $time, tr, tc, r, c, exp_v, act_v);
                    err_cnt++;
                end
            end
        end
    endtask

    // Start a run, collect four tiles in order, watch the stall rule
    task automatic run_and_collect(input bit bp, input bit mid_start);
        int got;
        int cycles;
        bit holding;
        logic [4*W-1:0] held;
        got = 0;
        cycles = 0;
        holding = 1'b0;
        held = '0;
        @(posedge clk);
        #1;
        start = 1'b1;
        out_ready = !bp;
        while (got < NUM_TILES && cycles < WAIT_LIMIT) begin
            @(posedge clk);
            cycles++;
            if (holding && !out_valid) begin
                $display("ERROR at %0t ns: result dropped before it was taken", $time);
                err_cnt++;
            end else if (holding && out_data !== held) begin
                $display("MISMATCH at %0t ns: out_data moved during stall, expected %h got %h",
                         $time, held, out_data);
                err_cnt++;
            end
            if (out_valid && out_ready) begin
                check_tile(got, out_data);
                res_q[got] = out_data;
                got++;
                holding = 1'b0;
            end else begin
                holding = out_valid;   // Offered but not taken
                held = out_data;
            end
            #1;
            start = mid_start && (cycles == 12);   // Stray start inside the run
            if (bp && cycles < HOLD_CYCLES) begin
                out_ready = 1'b0;      // First tile waits while the second one closes
            end else begin
                out_ready = bp ? 1'($urandom_range(0, 1)) : 1'b1;
            end
        end
        start = 1'b0;
        out_ready = 1'b1;
        if (got < NUM_TILES) begin
            $display("ERROR at %0t ns: run stalled with %0d of %0d results", $time, got, NUM_TILES);
            err_cnt++;
        end else if (done !== 1'b1) begin
            $display("ERROR at %0t ns: done not raised after the last result", $time);
            err_cnt++;
        end
        repeat (4) begin
            @(posedge clk);
            if (out_valid) begin
                $display("ERROR at %0t ns: extra result after the run", $time);
                err_cnt++;
            end
        end
    endtask

    task automatic report_test(input string name, input int errs_before);
        if (err_cnt == errs_before) begin
            pass_cnt++;
            $display("[%0t ns] %s passed", $time, name);
        end else begin
            fail_cnt++;
            $display("[%0t ns] %s failed with %0d errors", $time, name, err_cnt - errs_before);
        end
    endtask

    task automatic fill_random(input int span);
        for (int i = 0; i < `MM_ROWS_A; i++)
            for (int k = 0; k < `MM_INNER; k++)
                a_m[i][k] = W'($urandom_range(0, 2 * span - 1) - span);
        for (int k = 0; k < `MM_INNER; k++)
            for (int j = 0; j < `MM_COLS_B; j++)
                b_m[k][j] = W'($urandom_range(0, 2 * span - 1) - span);
    endtask

    task automatic identity_after_reset();
        int e0;
        e0 = err_cnt;
        if (out_valid !== 1'b0 || done !== 1'b0) begin
            $display("ERROR at %0t ns: out_valid or done high after reset", $time);
            err_cnt++;
        end
        for (int i = 0; i < `MM_ROWS_A; i++)
            for (int k = 0; k < `MM_INNER; k++)
                a_m[i][k] = W'((i + k - 3) * 256);          // Small integers
        for (int k = 0; k < `MM_INNER; k++)
            for (int j = 0; j < `MM_COLS_B; j++)
                b_m[k][j] = (k < 4) ? W'((k == j) * 256) : W'((j - k + 2) * 256);
        load_matrices();
        run_and_collect(1'b0, 1'b0);
        report_test("reset and identity", e0);
    endtask

    task automatic fractional_products();
        int e0;
        e0 = err_cnt;
        fill_random(1024);   // About +-4.0 with fraction bits
        load_matrices();
        run_and_collect(1'b0, 1'b0);
        report_test("fractional values", e0);
    endtask

    task automatic saturating_sums();
        int e0;
        e0 = err_cnt;
        for (int k = 0; k < `MM_INNER; k++) begin
            a_m[0][k] = 16'sh7FFF;
            a_m[1][k] = 16'sh8000;
            a_m[2][k] = 16'sh0100;
            a_m[3][k] = 16'shFF00;
            b_m[k][0] = 16'sh7FFF;
            b_m[k][1] = 16'sh0080;
            b_m[k][2] = 16'sh0000;
            b_m[k][3] = 16'sh0001;   // Stays in range
        end
        load_matrices();
        run_and_collect(1'b0, 1'b0);
        if (res_q[0][W-1:0] !== 16'h7FFF || res_q[0][3*W-1:2*W] !== 16'h8000) begin
            $display("MISMATCH at %0t ns: tile (0,0) clamp expected 7fff/8000 got %h/%h",
                     $time, res_q[0][W-1:0], res_q[0][3*W-1:2*W]);
            err_cnt++;
        end
        report_test("saturation", e0);
    endtask

    task automatic random_backpressure();
        int e0;
        e0 = err_cnt;
        fill_random(2048);
        load_matrices();
        run_and_collect(1'b1, 1'b0);
        report_test("back-pressure", e0);
    endtask

    task automatic restart_and_reload();
        int e0;
        e0 = err_cnt;
        run_and_collect(1'b0, 1'b1);   // Same data and a stray start mid-run
        prev_q = res_q;
        run_and_collect(1'b0, 1'b0);   // Rerun without reload
        for (int t = 0; t < NUM_TILES; t++) begin
            if (res_q[t] !== prev_q[t]) begin
                $display("MISMATCH at %0t ns: rerun tile %0d expected %h got %h",
                         $time, t, prev_q[t], res_q[t]);
                err_cnt++;
            end
        end
        // A word at tr=1, k=3 feeds only the lower tile row
        a_m[2][3] = 16'sh0280;
        a_m[3][3] = 16'shFD40;
        write_word(1'b0, `MM_INNER + 3, {a_m[3][3], a_m[2][3]});
        @(posedge clk);
        #1;
        load_en = 1'b0;
        run_and_collect(1'b0, 1'b0);
        for (int t = 0; t < 2; t++) begin
            if (res_q[t] !== prev_q[t]) begin
                $display("MISMATCH at %0t ns: untouched tile %0d expected %h got %h",
                         $time, t, prev_q[t], res_q[t]);
                err_cnt++;
            end
        end
        report_test("run control", e0);
    endtask

    // Watchdog over the whole test sequence
    initial begin
        #(WATCHDOG_NS);
        $display("Simulation timed out after %0d ns without finishing", WATCHDOG_NS);
        $display("TEST FAILED");
        $finish;
    end

    initial begin
        seed_val  = $urandom(60460);
        err_cnt   = 0;
        pass_cnt  = 0;
        fail_cnt  = 0;
        rst_n     = 1'b0;
        start     = 1'b0;
        load_en   = 1'b0;
        load_sel  = 1'b0;
        load_addr = '0;
        load_data = '0;
        out_ready = 1'b0;
        repeat (16) @(posedge clk);
        #1;
        rst_n = 1'b1;
        identity_after_reset();
        fractional_products();
        saturating_sums();
        random_backpressure();
        restart_and_reload();
        $display("Tests passed %0d, failed %0d", pass_cnt, fail_cnt);
        if (fail_cnt == 0 && err_cnt == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

//--- source/matmul_w_bram.sv
// Matrix multiplier with operand RAMs
// Host loads A and B, pulses start, collects four 2x2 tiles of C
// Tiles leave in row-major order on a valid/ready port
`timescale 1ns/1ps
`include "matmul_macros.svh"

module matmul_w_bram import matmul_pkg::*; (
    input  logic                                      clk,
    input  logic                                      rst_n,
    input  logic                                      start,

    // Host load port, one word per strobe
    input  logic                                      load_en,
    input  logic                                      load_sel,    // 0 A, 1 B
    input  logic [`MM_ADDR_WIDTH-1:0]                 load_addr,
    input  logic [`MM_BLOCK*`MM_WIDTH-1:0]            load_data,

    // Result port
    output logic                                      out_valid,
    input  logic                                      out_ready,
    output logic [`MM_BLOCK*`MM_BLOCK*`MM_WIDTH-1:0]  out_data,

    output logic                                      done
);

    logic                      wr_en_a;
    logic                      wr_en_b;
    logic                      rd_en;        // Shared by both RAMs
    logic [`MM_ADDR_WIDTH-1:0] a_addr;
    logic [`MM_ADDR_WIDTH-1:0] b_addr;
    logic                      res_accept;
    tile_result_u              res_tile;

    operand_if ops_if ();

    // Load strobe steered by select
    assign wr_en_a = load_en && !load_sel;
    assign wr_en_b = load_en && load_sel;

    assign res_accept = out_valid && out_ready;
    assign out_data   = res_tile.raw;

    // A rows, two per word
    operand_bram ram_a (
        .clk     (clk),
        .rst_n   (rst_n),
        .wr_en   (wr_en_a),
        .wr_addr (load_addr),
        .wr_data (load_data),
        .rd_en   (rd_en),
        .rd_addr (a_addr),
        .rd_data (ops_if.a_word)
    );

    // B columns, two per word
    operand_bram ram_b (
        .clk     (clk),
        .rst_n   (rst_n),
        .wr_en   (wr_en_b),
        .wr_addr (load_addr),
        .wr_data (load_data),
        .rd_en   (rd_en),
        .rd_addr (b_addr),
        .rd_data (ops_if.b_word)
    );

    tile_sequencer u_seq (
        .clk        (clk),
        .rst_n      (rst_n),
        .start      (start),
        .res_accept (res_accept),
        .done       (done),
        .rd_en      (rd_en),
        .a_addr     (a_addr),
        .b_addr     (b_addr),
        .ops        (ops_if.source)
    );

    mac_array u_array (
        .clk       (clk),
        .rst_n     (rst_n),
        .ops       (ops_if.sink),
        .res_valid (out_valid),
        .res_ready (out_ready),
        .res_data  (res_tile)
    );

endmodule

//--- matmul_core/tile_sequencer.sv
// Tile sequencer
// Walks tiles in row-major order and k within each tile
// Issues RAM reads, aligns valid/first/last to read data, flags done
`timescale 1ns/1ps
`include "matmul_macros.svh"

module tile_sequencer import matmul_pkg::*; (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      start,
    input  logic                      res_accept,   // One result taken at the port
    output logic                      done,
    output logic                      rd_en,
    output logic [`MM_ADDR_WIDTH-1:0] a_addr,
    output logic [`MM_ADDR_WIDTH-1:0] b_addr,
    operand_if.source                 ops
);

    localparam int AW        = `MM_ADDR_WIDTH;
    localparam int ROW_TILES = `MM_ROWS_A / `MM_BLOCK;
    localparam int COL_TILES = `MM_COLS_B / `MM_BLOCK;
    localparam int NUM_TILES = ROW_TILES * COL_TILES;
    localparam int K_W       = $clog2(`MM_INNER);
    localparam int TR_W      = (ROW_TILES > 1) ? $clog2(ROW_TILES) : 1;
    localparam int TC_W      = (COL_TILES > 1) ? $clog2(COL_TILES) : 1;
    localparam int CNT_W     = $clog2(NUM_TILES + 1);

    typedef enum logic {
        IDLE,
        RUN
    } state_t;

    state_t            state;
    logic [K_W-1:0]    k;            // Next k to read
    logic [TC_W-1:0]   tc;           // Tile column
    logic [TR_W-1:0]   tr;           // Tile row
    logic              issued_all;   // Every read of the run sent
    logic [CNT_W-1:0]  tiles_out;    // Results taken so far
    logic              advance;
    logic              k_wrap;
    logic              tc_wrap;
    logic              tr_wrap;

    // Output stage is free or is handing its beat over
    assign advance = !ops.valid || ops.ready;

    // Reads only when the stream moves, so RAM data holds in a stall
    assign rd_en = (state == RUN) && !issued_all && advance;

    assign k_wrap  = (k == K_W'(`MM_INNER - 1));
    assign tc_wrap = (tc == TC_W'(COL_TILES - 1));
    assign tr_wrap = (tr == TR_W'(ROW_TILES - 1));

    // Layout rule, tile index times K plus k
    assign a_addr = AW'(tr * `MM_INNER + k);
    assign b_addr = AW'(tc * `MM_INNER + k);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state      <= IDLE;
            k          <= '0;
            tc         <= '0;
            tr         <= '0;
            issued_all <= 1'b0;
            tiles_out  <= '0;
            done       <= 1'b0;
        end else begin
            case (state)
                IDLE: begin
                    if (start) begin                 // Start only taken here
                        state      <= RUN;
                        k          <= '0;
                        tc         <= '0;
                        tr         <= '0;
                        issued_all <= 1'b0;
                        tiles_out  <= '0;
                        done       <= 1'b0;
                    end
                end
                RUN: begin
                    if (rd_en) begin
                        k <= k + 1'b1;
                        if (k_wrap) begin
                            k  <= '0;
                            tc <= tc + 1'b1;
                            if (tc_wrap) begin
                                tc <= '0;
                                tr <= tr + 1'b1;
                                if (tr_wrap) begin
                                    tr         <= '0;
                                    issued_all <= 1'b1;   // Final read out
                                end
                            end
                        end
                    end
                    if (res_accept) begin
                        tiles_out <= tiles_out + 1'b1;
                        if (tiles_out == CNT_W'(NUM_TILES - 1)) begin
                            state <= IDLE;
                            done  <= 1'b1;     // Held until next start
                        end
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    // Beat flags trail the read by one cycle, matching RAM latency
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ops.valid <= 1'b0;
            ops.first <= 1'b0;
            ops.last  <= 1'b0;
        end else if (rd_en) begin
            ops.valid <= 1'b1;
            ops.first <= (k == '0);
            ops.last  <= k_wrap;
        end else if (advance) begin
            ops.valid <= 1'b0;         // Nothing left to offer
        end
    end

endmodule

//--- matmul_core/mac_array.sv
// 2x2 MAC array
// Each beat is an outer product of two A lanes and two B lanes
// Holds one finished tile in a result register with valid/ready output
`timescale 1ns/1ps
`include "matmul_macros.svh"

module mac_array import matmul_pkg::*; (
    input  logic         clk,
    input  logic         rst_n,
    operand_if.sink      ops,
    output logic         res_valid,
    input  logic         res_ready,
    output tile_result_u res_data
);

    localparam int B = `MM_BLOCK;

    logic beat;                  // Handshake on the operand stream
    logic last_d;                // Last beat registered one cycle ago
    fix_t sum_grid [B][B];       // Element outputs

    assign beat = ops.valid && ops.ready;

    // Stall only a closing beat that would overwrite an undrained tile
    // Ready also follows valid so it stays low while nothing is offered
    assign ops.ready = ops.valid && !(ops.last && res_valid && !res_ready);

    for (genvar r = 0; r < B; r++) begin : g_row
        for (genvar c = 0; c < B; c++) begin : g_col
            mac_pe u_pe (
                .clk    (clk),
                .rst_n  (rst_n),
                .a      (ops.a_word[r]),   // Row lane of A
                .b      (ops.b_word[c]),   // Column lane of B
                .acc_en (beat),
                .clear  (ops.first),
                .sum    (sum_grid[r][c])
            );
        end
    end

    // Accumulators settle on the last beat edge, capture one edge later
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            last_d <= 1'b0;
        end else begin
            last_d <= beat && ops.last;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            res_valid <= 1'b0;
        end else if (last_d) begin
            res_valid <= 1'b1;          // New tile in
        end else if (res_ready) begin
            res_valid <= 1'b0;          // Drained
        end
    end

    // Payload register, held while res_valid waits
    always_ff @(posedge clk) begin
        if (last_d) begin
            for (int r = 0; r < B; r++) begin
                for (int c = 0; c < B; c++) begin
                    res_data.elem[r][c] <= sum_grid[r][c];
                end
            end
        end
    end

endmodule

//--- matmul_core/mac_pe.sv
// MAC processing element
// Accumulates a*b at 40 bits, first beat loads instead of adding
// Output is the accumulator truncated and saturated back to Q8.8
`timescale 1ns/1ps
`include "matmul_macros.svh"

module mac_pe import matmul_pkg::*; (
    input  logic clk,
    input  logic rst_n,
    input  fix_t a,
    input  fix_t b,
    input  logic acc_en,
    input  logic clear,
    output fix_t sum
);

    localparam int W  = `MM_WIDTH;
    localparam int AW = `MM_ACC_WIDTH;

    acc_t prod;      // Full product, sign extended
    acc_t acc;
    acc_t shifted;   // Back to Q8.8 scale
    logic ovf_hi;
    logic ovf_lo;

    // Signed operands, 40 bit context
    assign prod = a * b;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            acc <= '0;
        end else if (acc_en) begin
            if (clear) begin
                acc <= prod;           // k == 0 starts a new tile
            end else begin
                acc <= acc + prod;
            end
        end
    end

    // Arithmetic shift, rounds toward minus infinity
    assign shifted = acc >>> `MM_FRAC;

    // Bits above the result sign must all copy the accumulator sign
    assign ovf_hi = !shifted[AW-1] && (|shifted[AW-2:W-1]);
    assign ovf_lo = shifted[AW-1] && !(&shifted[AW-2:W-1]);

    always_comb begin
        if (ovf_hi) begin
            sum = {1'b0, {(W-1){1'b1}}};   // 0x7FFF
        end else if (ovf_lo) begin
            sum = {1'b1, {(W-1){1'b0}}};   // 0x8000
        end else begin
            sum = shifted[W-1:0];
        end
    end

endmodule

//--- source/operand_bram.sv
// Operand RAM, simple dual port
// One write port, one registered read port with latency 1
// Read output holds unless rd_en is high
`timescale 1ns/1ps
`include "matmul_macros.svh"

module operand_bram import matmul_pkg::*; (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      wr_en,
    input  logic [`MM_ADDR_WIDTH-1:0] wr_addr,
    input  lane_word_t                wr_data,
    input  logic                      rd_en,
    input  logic [`MM_ADDR_WIDTH-1:0] rd_addr,
    output lane_word_t                rd_data
);

    localparam int DEPTH = 1 << `MM_ADDR_WIDTH;

    lane_word_t mem [DEPTH];   // Behavioral array

    // Host write port
    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_data;
        end
    end

    // Read port, output register cleared by reset
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rd_data <= '0;
        end else if (rd_en) begin
            rd_data <= mem[rd_addr];   // Stalls keep the last word
        end
    end

endmodule

//--- common/operand_if.sv
// Operand stream from the tile sequencer to the MAC array
// Valid/ready handshake, word data comes straight from the RAMs
`timescale 1ns/1ps

interface operand_if import matmul_pkg::*; ();

    logic       valid;     // Beat offered
    logic       ready;     // Beat taken by the array
    lane_word_t a_word;    // Two rows of A at one k
    lane_word_t b_word;    // Two columns of B at one k
    logic       first;     // k == 0, clears accumulators
    logic       last;      // k == K-1, closes the tile

    // Sequencer side
    // Words are driven by the RAM read ports at the top level
    modport source (
        output valid,
        output first,
        output last,
        input  ready
    );

    // MAC array side
    modport sink (
        input  valid,
        input  a_word,
        input  b_word,
        input  first,
        input  last,
        output ready
    );

endinterface

//--- common/matmul_pkg.sv
// Matrix multiplier types
// Fixed-point element, accumulator, RAM word and result tile
`include "matmul_macros.svh"

package matmul_pkg;

    // One Q8.8 element
    typedef logic signed [`MM_WIDTH-1:0] fix_t;

    // Accumulator, full product precision plus headroom
    typedef logic signed [`MM_ACC_WIDTH-1:0] acc_t;

    // RAM word of two lanes
    // Lane 0 in the low half
    typedef fix_t [`MM_BLOCK-1:0] lane_word_t;

    // Result tile, raw bus view or element view
    // Element (r,c) sits at bits 16*(2r+c)
    typedef union packed {
        logic [`MM_BLOCK*`MM_BLOCK*`MM_WIDTH-1:0] raw;   // Port view
        fix_t [`MM_BLOCK-1:0][`MM_BLOCK-1:0]      elem;  // [row][col] view
    } tile_result_u;

endpackage

//--- common/matmul_macros.svh
// Matrix multiplier dimensions and widths
// Shared by the package, the RAMs, the core and the top level
`ifndef MATMUL_MACROS_SVH
`define MATMUL_MACROS_SVH

// Element format, Q8.8 signed
`define MM_WIDTH 16
`define MM_FRAC 8

// Matrix shape, C = A(4x8) * B(8x4)
`define MM_INNER 8          // Inner dimension K
`define MM_ROWS_A 4         // Rows of A
`define MM_COLS_B 4         // Columns of B

// Tile edge, also lanes per RAM word
`define MM_BLOCK 2

// Full precision accumulation
`define MM_ACC_WIDTH 40

// RAM depth 16 = (rows / block) * inner
`define MM_ADDR_WIDTH 4

`endif
